/* uart_echo_pkg.sv */
// fixed 8N1 frame, 16x oversampling; the error character replaces bytes with a bad stop bit
package uart_echo_pkg;

   localparam int data_w  = 8;          // bits per uart byte
   localparam int entry_w = data_w + 1; // fifo entry, frame_err above the byte
   localparam int os_rate = 16;         // oversample ticks per bit

   localparam logic [data_w-1:0] err_char = 8'h3f; // ascii '?'

   // receiver FSM
   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_t;

   // transmitter FSM
   typedef enum logic [1:0] {
      tx_idle,
      tx_start,
      tx_data,
      tx_stop
   } tx_state_t;

endpackage

/* uart_byte_if.sv */
// four-phase req/ack link; data and frame_err must hold while req is high
`timescale 1ns/1ps

interface uart_byte_if
   import uart_echo_pkg::*;
   ();

   logic              req;       // source has a byte
   logic              ack;       // sink took it
   logic [data_w-1:0] data;
   logic              frame_err; // stop bit was low

   modport source (output req, output data, output frame_err, input ack);

   modport sink (input req, input data, input frame_err, output ack);

endinterface

/* baud_gen.sv */
// clk_per_tick must be at least 1; with 1 the tick is high on every clock
`timescale 1ns/1ps

module baud_gen
   #(
      parameter int clk_per_tick = 54
   )
   (
      input  logic clk,
      input  logic reset,
      output logic tick
   );

   localparam int cnt_w = (clk_per_tick > 1) ? $clog2(clk_per_tick) : 1;

   logic [cnt_w-1:0] cnt;

   // free running, wraps at clk_per_tick
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         cnt <= '0;
      else if (cnt == cnt_w'(clk_per_tick - 1))
         cnt <= '0;
      else
         cnt <= cnt + 1'b1;
   end

   assign tick = (cnt == cnt_w'(clk_per_tick - 1)); // one clock per wrap

   // single-cycle pulses whenever the divider really divides
   a_tick_single : assert property (@(posedge clk) disable iff (reset)
      (clk_per_tick > 1) && tick |=> !tick);

endmodule

/* uart_rx.sv */
// 8N1 only, no parity or break detect; a new frame finishing before the last ack is dropped
`timescale 1ns/1ps

module uart_rx
   import uart_echo_pkg::*;
   (
      input  logic        clk,
      input  logic        reset,
      input  logic        tick,
      input  logic        rxd,
      uart_byte_if.source rx_link
   );

   localparam int tc_w = $clog2(os_rate);
   localparam int bc_w = $clog2(data_w);
   localparam logic [tc_w-1:0] mid_cnt  = tc_w'(os_rate / 2 - 1);
   localparam logic [tc_w-1:0] last_cnt = tc_w'(os_rate - 1);

   rx_state_t         state;
   logic [tc_w-1:0]   tick_cnt;  // ticks into the current bit
   logic [bc_w-1:0]   bit_cnt;
   logic [data_w-1:0] shift_reg;
   logic              rxd_meta;
   logic              rxd_sync;
   logic              rxd_last;  // for falling edge detect
   logic              sample_bit;
   logic              frame_done;
   logic              load;

   // two-flop synchronizer, line idles high
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_last <= 1'b1;
      end
      else
      begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_last <= rxd_sync;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state    <= rx_idle;
         tick_cnt <= '0;
         bit_cnt  <= '0;
      end
      else
      begin
         case (state)
            rx_idle:
               if (rxd_last && !rxd_sync) // falling edge, maybe a start bit
               begin
                  state    <= rx_start;
                  tick_cnt <= '0;
               end
            rx_start:
               if (tick)
               begin
                  if (tick_cnt == mid_cnt)
                  begin
                     tick_cnt <= '0;
                     bit_cnt  <= '0;
                     state    <= rxd_sync ? rx_idle : rx_data; // high again means glitch
                  end
                  else
                     tick_cnt <= tick_cnt + 1'b1;
               end
            rx_data:
               if (tick)
               begin
                  tick_cnt <= tick_cnt + 1'b1;
                  if (tick_cnt == last_cnt)
                  begin
                     tick_cnt <= '0;
                     bit_cnt  <= bit_cnt + 1'b1;
                     if (bit_cnt == bc_w'(data_w - 1))
                        state <= rx_stop;
                  end
               end
            rx_stop:
               if (tick)
               begin
                  tick_cnt <= tick_cnt + 1'b1;
                  if (tick_cnt == last_cnt) // mid stop bit
                  begin
                     tick_cnt <= '0;
                     state    <= rx_idle;
                  end
               end
            default:
               state <= rx_idle;
         endcase
      end
   end

   assign sample_bit = tick && (state == rx_data) && (tick_cnt == last_cnt);
   assign frame_done = tick && (state == rx_stop) && (tick_cnt == last_cnt);
   assign load       = frame_done && !rx_link.req && !rx_link.ack;

   // lsb arrives first
   always_ff @(posedge clk)
   begin
      if (sample_bit)
         shift_reg <= {rxd_sync, shift_reg[data_w-1:1]};
   end

   // output byte, held for the whole handshake
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         rx_link.data      <= shift_reg;
         rx_link.frame_err <= !rxd_sync; // low stop sample
      end
   end

   // source side of the four-phase link
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         rx_link.req <= 1'b0;
      else if (load)
         rx_link.req <= 1'b1;
      else if (rx_link.req && rx_link.ack)
         rx_link.req <= 1'b0;
   end

   // byte must not move under the FIFO while it is offered
   a_data_stable : assert property (@(posedge clk) disable iff (reset)
      rx_link.req |=> !rx_link.req || $stable(rx_link.data));

endmodule

/* fifo.sv */
// depth is 2**addr_w; a byte offered while full is acked and lost; overrun stays set until reset
`timescale 1ns/1ps

module fifo
   import uart_echo_pkg::*;
   #(
      parameter int addr_w = 4
   )
   (
      input  logic        clk,
      input  logic        reset,
      uart_byte_if.sink   wr_link,
      uart_byte_if.source rd_link,
      output logic        overrun
   );

   logic [entry_w-1:0] array_reg [2**addr_w]; // {frame_err, data}
   logic [addr_w-1:0]  w_ptr_reg;
   logic [addr_w-1:0]  w_ptr_next;
   logic [addr_w-1:0]  w_ptr_succ;
   logic [addr_w-1:0]  r_ptr_reg;
   logic [addr_w-1:0]  r_ptr_next;
   logic [addr_w-1:0]  r_ptr_succ;
   logic               full_reg;
   logic               full_next;
   logic               empty_reg;
   logic               empty_next;
   logic               wr;    // new byte offered on the first clock of req
   logic               wr_en; // actually stored
   logic               rd;    // pop when tx takes the head

   assign wr    = wr_link.req && !wr_link.ack;
   assign wr_en = wr && !full_reg;
   assign rd    = rd_link.req && rd_link.ack;

   // register file write port
   always_ff @(posedge clk)
   begin
      if (wr_en)
         array_reg[w_ptr_reg] <= {wr_link.frame_err, wr_link.data};
   end

   assign {rd_link.frame_err, rd_link.data} = array_reg[r_ptr_reg]; // head entry

   // sink side ack follows req by one clock
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         wr_link.ack <= 1'b0;
      else
         wr_link.ack <= wr_link.req;
   end

   // source side offers the head while not empty
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         rd_link.req <= 1'b0;
      else if (rd)
         rd_link.req <= 1'b0;
      else if (!rd_link.req && !rd_link.ack && !empty_reg)
         rd_link.req <= 1'b1;
   end

   // pointers and flags
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         w_ptr_reg <= '0;
         r_ptr_reg <= '0;
         full_reg  <= 1'b0;
         empty_reg <= 1'b1;
         overrun   <= 1'b0;
      end
      else
      begin
         w_ptr_reg <= w_ptr_next;
         r_ptr_reg <= r_ptr_next;
         full_reg  <= full_next;
         empty_reg <= empty_next;
         if (wr && full_reg)
            overrun <= 1'b1; // sticky
      end
   end

   always_comb
   begin
      w_ptr_succ = w_ptr_reg + 1'b1;
      r_ptr_succ = r_ptr_reg + 1'b1;
      w_ptr_next = w_ptr_reg;
      r_ptr_next = r_ptr_reg;
      full_next  = full_reg;
      empty_next = empty_reg;
      case ({wr_en, rd})
         2'b01: // pop only
         begin
            r_ptr_next = r_ptr_succ;
            full_next  = 1'b0;
            if (r_ptr_succ == w_ptr_reg)
               empty_next = 1'b1;
         end
         2'b10: // push only
         begin
            w_ptr_next = w_ptr_succ;
            empty_next = 1'b0;
            if (w_ptr_succ == r_ptr_reg)
               full_next = 1'b1;
         end
         2'b11: // push and pop keep the fill level
         begin
            w_ptr_next = w_ptr_succ;
            r_ptr_next = r_ptr_succ;
         end
         default: ;
      endcase
   end

   // a stored byte never lands on an unread entry
   a_no_write_full : assert property (@(posedge clk) disable iff (reset)
      wr_en |-> empty_reg || (w_ptr_reg != r_ptr_reg));

   // tx never completes a handshake on an empty queue
   a_no_pop_empty : assert property (@(posedge clk) disable iff (reset)
      rd |-> !empty_reg);

endmodule

/* uart_tx.sv */
// 8N1 only; tx_pause blocks the next frame but never cuts one short
`timescale 1ns/1ps

module uart_tx
   import uart_echo_pkg::*;
   (
      input  logic      clk,
      input  logic      reset,
      input  logic      tick,
      input  logic      tx_pause,
      uart_byte_if.sink tx_link,
      output logic      txd
   );

   localparam int tc_w = $clog2(os_rate);
   localparam int bc_w = $clog2(data_w);
   localparam logic [tc_w-1:0] last_cnt = tc_w'(os_rate - 1);

   tx_state_t         state;
   logic [tc_w-1:0]   tick_cnt;
   logic [bc_w-1:0]   bit_cnt;
   logic [data_w-1:0] shift_reg;
   logic              load;
   logic              shift_en;

   // take a byte only when idle and allowed
   assign load     = (state == tx_idle) && tx_link.req && !tx_link.ack && !tx_pause;
   assign shift_en = tick && (state == tx_data) && (tick_cnt == last_cnt);

   always_ff @(posedge clk)
   begin
      if (load)
         shift_reg <= tx_link.frame_err ? err_char : tx_link.data; // '?' for bad frames
      else if (shift_en)
         shift_reg <= shift_reg >> 1;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state       <= tx_idle;
         tick_cnt    <= '0;
         bit_cnt     <= '0;
         txd         <= 1'b1; // line idles high
         tx_link.ack <= 1'b0;
      end
      else
      begin
         if (tx_link.ack && !tx_link.req)
            tx_link.ack <= 1'b0; // last phase of the handshake
         if (load)
         begin
            tx_link.ack <= 1'b1;
            state       <= tx_start;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
         end
         else if (tick && state != tx_idle)
         begin
            tick_cnt <= tick_cnt + 1'b1;
            // new bit value on the first tick of each bit period
            if (tick_cnt == '0)
            begin
               case (state)
                  tx_start: txd <= 1'b0;
                  tx_data:  txd <= shift_reg[0];
                  default:  txd <= 1'b1;
               endcase
            end
            if (tick_cnt == last_cnt)
            begin
               case (state)
                  tx_start: state <= tx_data;
                  tx_data:
                  begin
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == bc_w'(data_w - 1))
                        state <= tx_stop;
                  end
                  default:  state <= tx_idle; // stop bit done
               endcase
            end
         end
      end
   end

   // stop bit must have restored the line before idle
   a_idle_high : assert property (@(posedge clk) disable iff (reset)
      state == tx_idle |-> txd);

endmodule

/* uart_echo.sv */
// bit time is 16*clk_per_tick clocks; overrun is sticky until reset
`timescale 1ns/1ps

module uart_echo
   #(
      parameter int clk_per_tick = 54, // about 115200 baud at 100 MHz
      parameter int addr_w       = 4   // 16 byte queue
   )
   (
      input  logic clk,
      input  logic reset,
      input  logic rxd,
      input  logic tx_pause,
      output logic txd,
      output logic overrun
   );

   logic tick; // shared 16x oversample tick

   uart_byte_if rx_link ();
   uart_byte_if tx_link ();

   baud_gen #(
      .clk_per_tick (clk_per_tick)
   ) u_baud_gen (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

   uart_rx u_uart_rx (
      .clk     (clk),
      .reset   (reset),
      .tick    (tick),
      .rxd     (rxd),
      .rx_link (rx_link.source)
   );

   fifo #(
      .addr_w (addr_w)
   ) u_fifo (
      .clk     (clk),
      .reset   (reset),
      .wr_link (rx_link.sink),
      .rd_link (tx_link.source),
      .overrun (overrun)
   );

   uart_tx u_uart_tx (
      .clk      (clk),
      .reset    (reset),
      .tick     (tick),
      .tx_pause (tx_pause),
      .tx_link  (tx_link.sink),
      .txd      (txd)
   );

endmodule

/* tb_uart_echo.sv */
// bit time is fixed at 64 clocks (clk_per_tick 4); the first error ends the run
`timescale 1ns/1ps

module tb_uart_echo;

   localparam int clk_per_tick = 4;
   localparam int addr_w       = 4;
   localparam int bit_clks     = 16 * clk_per_tick; // 16x oversampling
   localparam int half_bit     = bit_clks / 2;
   localparam int frame_clks   = 10 * bit_clks;     // start, 8 data, stop
   localparam int depth        = 2 ** addr_w;
   localparam logic [7:0] err_char = 8'h3f;         // '?' for bad frames

   logic clk;
   logic reset;
   logic rxd;
   logic tx_pause;
   logic txd;
   logic overrun;

   logic [7:0]  exp_q [$];      // reference echo stream
   logic [7:0]  got_q [$];      // bytes seen on txd
   string       test_name;
   int          held_cnt;       // bytes sent while paused
   int unsigned lcg_state = 74469;
   bit          mon_busy;
   int          mon_cnt;
   int          mon_k;
   logic [7:0]  mon_byte;

   uart_echo #(
      .clk_per_tick (clk_per_tick),
      .addr_w       (addr_w)
   ) u_dut (
      .clk      (clk),
      .reset    (reset),
      .rxd      (rxd),
      .tx_pause (tx_pause),
      .txd      (txd),
      .overrun  (overrun)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 100 MHz
   end

   function automatic logic [7:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[23:16]; // middle bits since low ones repeat too soon
   endfunction

   // expected echo for one received frame
   function automatic logic [7:0] expected_echo(input logic [7:0] b, input logic bad_stop);
      if (bad_stop)
         return err_char;
      return b;
   endfunction

   task automatic stop_run();
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input logic [7:0] expected,
                              input logic [7:0] actual);
      if (actual !== expected)
      begin
         $display("MISMATCH test=%s %s expected=0x%02h actual=0x%02h",
                  test_name, what, expected, actual);
         stop_run();
      end
   endtask

   // one bit period on rxd driven just after the edge
   task automatic drive_bit(input logic v);
      @(posedge clk);
      #1;
      rxd = v;
      repeat (bit_clks - 1) @(posedge clk);
   endtask

   task automatic send_byte(input logic [7:0] b, input logic bad_stop);
      int i;
      if (!tx_pause || held_cnt < depth) // a full queue drops the byte
         exp_q.push_back(expected_echo(b, bad_stop));
      if (tx_pause)
         held_cnt++;
      drive_bit(1'b0);
      for (i = 0; i < 8; i++)
         drive_bit(b[i]); // lsb first
      drive_bit(!bad_stop);
      if (bad_stop)
         drive_bit(1'b1); // idle gap so the next start edge is seen
   endtask

   // wait until every expected byte has come back
   task automatic wait_drain(input int max_clks);
      int n;
      n = 0;
      while ((exp_q.size() != 0 || mon_busy) && n < max_clks)
      begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0 || mon_busy)
      begin
         $display("timeout: test %s stalled, %0d bytes never echoed on txd",
                  test_name, exp_q.size());
         stop_run();
      end
   endtask

   // line must stay idle for the whole window
   task automatic watch_idle(input int clks, input logic exp_overrun);
      repeat (clks)
      begin
         @(negedge clk);
         check_value("txd idle", 8'h01, {7'b0, txd});
         check_value("overrun", {7'b0, exp_overrun}, {7'b0, overrun});
      end
   endtask

   // txd monitor sampled on the falling edge
   always @(negedge clk)
   begin
      if (reset)
         mon_busy = 1'b0;
      else if (!mon_busy)
      begin
         if (txd == 1'b0) // leading edge of a start bit
         begin
            mon_busy = 1'b1;
            mon_cnt  = 0;
         end
      end
      else
      begin
         mon_cnt = mon_cnt + 1;
         if (mon_cnt >= half_bit && (mon_cnt - half_bit) % bit_clks == 0)
         begin
            mon_k = (mon_cnt - half_bit) / bit_clks; // 0 start, 1..8 data, 9 stop
            if (mon_k == 0)
               check_value("start bit on txd", 8'h00, {7'b0, txd});
            else if (mon_k <= 8)
               mon_byte[mon_k-1] = txd;
            else
            begin
               check_value("stop bit on txd", 8'h01, {7'b0, txd});
               got_q.push_back(mon_byte);
               mon_busy = 1'b0;
            end
         end
      end
   end

   // compare each echoed byte with the reference queue head
   always @(posedge clk)
   begin
      logic [7:0] got;
      logic [7:0] exp;
      if (got_q.size() > 0)
      begin
         got = got_q.pop_front();
         if (exp_q.size() == 0)
         begin
            $display("unexpected byte 0x%02h on txd during test %s", got, test_name);
            stop_run();
         end
         else
         begin
            exp = exp_q.pop_front();
            check_value("echoed byte", exp, got);
         end
      end
   end

   initial
   begin
      int i;
      reset     = 1'b1;
      rxd       = 1'b1;
      tx_pause  = 1'b0;
      held_cnt  = 0;
      test_name = "reset";
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      test_name = "reset idle";
      watch_idle(5 * bit_clks, 1'b0);

      test_name = "single byte";
      send_byte(8'ha5, 1'b0);
      wait_drain(3 * frame_clks);

      test_name = "random burst";
      for (i = 0; i < 20; i++)
         send_byte(lcg_next(), 1'b0); // back to back with no gap
      wait_drain(4 * frame_clks);

      test_name = "framing error";
      send_byte(8'h41, 1'b0);
      send_byte(8'h5a, 1'b1);
      send_byte(8'h42, 1'b0);
      wait_drain(4 * frame_clks);

      test_name = "pause and overrun";
      @(posedge clk);
      #1;
      tx_pause = 1'b1;
      held_cnt = 0;
      for (i = 0; i < depth + 1; i++)
      begin
         if (i == depth)
         begin
            @(negedge clk);
            check_value("overrun before drop", 8'h00, {7'b0, overrun}); // queue just filled
         end
         send_byte(lcg_next(), 1'b0); // last one finds the queue full
      end
      @(negedge clk);
      check_value("overrun after fill", 8'h01, {7'b0, overrun});
      check_value("bytes held", 8'(depth), 8'(exp_q.size()));
      @(posedge clk);
      #1;
      tx_pause = 1'b0;
      wait_drain((depth + 4) * frame_clks);
      watch_idle(3 * bit_clks, 1'b1); // dropped byte must never show up

      if (exp_q.size() != 0 || got_q.size() != 0 || mon_busy)
      begin
         $display("reference queue not empty at end of run");
         stop_run();
      end
      else
      begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

/* uart_echo.f */
uart_echo_pkg.sv
uart_byte_if.sv
baud_gen.sv
uart_rx.sv
fifo.sv
uart_tx.sv
uart_echo.sv
tb_uart_echo.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uart_echo
FILELIST  ?= uart_echo.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  := Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
